// File: src/disp_cfg.svh
/* Dispatch stage configuration
   Core width, register count and reset PC */

`ifndef DISP_CFG_SVH
`define DISP_CFG_SVH

// Datapath width of the core
`define DISP_XLEN     32

// General purpose registers, x0 included
`define DISP_NREGS    32

// First fetch address after reset
`define DISP_PC_RESET 32'h8000_0000

`endif

// File: src/disp_pkg.sv
/* Dispatch stage types
   Encodings and bundles shared by the stage, register file and testbench */

`include "disp_cfg.svh"

package disp_pkg;

    // Functional unit
    typedef enum logic [2:0] {
        FU_ALU = 3'd0,
        FU_LSU = 3'd1,
        FU_CFU = 3'd2,
        FU_CSR = 3'd3,
        FU_MUL = 3'd4
    } fu_e;

    // Micro-op code
    typedef enum logic [4:0] {
        ALU_ADD   = 5'd0,
        LSU_LOAD  = 5'd1,
        LSU_STORE = 5'd2,
        CFU_BEQ   = 5'd3,                       // Conditional
        CFU_BNE   = 5'd4,                       // Conditional
        CFU_JAL   = 5'd5,
        CFU_JALR  = 5'd6,
        CSR_RW    = 5'd7
    } uop_e;

    // ----------------------------------------
    // Operand source selects

    typedef enum logic [1:0] {OPRA_NONE, OPRA_RS1, OPRA_PCIM, OPRA_CSRI} opra_sel_e;
    typedef enum logic [1:0] {OPRB_NONE, OPRB_RS2, OPRB_IMM} oprb_sel_e;
    typedef enum logic [1:0] {OPRC_NONE, OPRC_RS2, OPRC_CSRA, OPRC_PCIM} oprc_sel_e;

    typedef struct packed {
        opra_sel_e a;
        oprb_sel_e b;
        oprc_sel_e c;
    } opr_src_t;

    // ----------------------------------------
    // Stage bundles

    typedef struct packed {
        logic [4:0]            rd;
        logic [4:0]            rs1;
        logic [4:0]            rs2;
        logic [`DISP_XLEN-1:0] imm;
        uop_e                  uop;
        fu_e                   fu;
        logic                  trap;
        opr_src_t              opr_src;
        logic [1:0]            size;             // [1] 32-bit, [0] 16-bit
        logic [31:0]           instr;
    } s2_bundle_t;

    typedef struct packed {
        logic [4:0]            rd;
        logic [`DISP_XLEN-1:0] pc;
        uop_e                  uop;
        fu_e                   fu;
        logic [1:0]            size;
        logic [31:0]           instr;
        logic [`DISP_XLEN-1:0] opr_a;
        logic [`DISP_XLEN-1:0] opr_b;
        logic [`DISP_XLEN-1:0] opr_c;
        logic                  trap;
    } s3_bundle_t;

    // Result of a later stage
    typedef struct packed {
        logic [4:0]            rd;
        logic [`DISP_XLEN-1:0] wdata;
        logic                  load;
        logic                  csr;
    } fwd_t;

    typedef struct packed {
        logic                  wen;
        logic [4:0]            rd;
        logic [`DISP_XLEN-1:0] wdata;
    } gpr_wr_t;

endpackage

// File: src/gpr_file.sv
/* General purpose register file
   Two combinational read ports, one write port, x0 hardwired to zero */

`timescale 1ns/1ps
`include "disp_cfg.svh"

module gpr_file import disp_pkg::*; (
    input  logic                  g_clk,        // Core clock
    input  logic                  g_resetn,     // Sync reset, active low
    input  logic [4:0]            rs1_addr,     // Read port 1 address
    output logic [`DISP_XLEN-1:0] rs1_data,     // Read port 1 data
    input  logic [4:0]            rs2_addr,     // Read port 2 address
    output logic [`DISP_XLEN-1:0] rs2_data,     // Read port 2 data
    input  gpr_wr_t               wr            // Write port
);

    // x1 upwards, no storage for x0
    logic [`DISP_XLEN-1:0] regs [1:`DISP_NREGS-1];

    logic wr_ok;

    assign wr_ok = g_resetn && wr.wen && (wr.rd != 5'd0);   // Drop x0 writes

    // ----------------------------------------
    // Write port

    always_ff @(posedge g_clk) begin
        if (wr_ok) begin
            regs[wr.rd] <= wr.wdata;                // Visible next cycle
        end
    end

    // ----------------------------------------
    // Read ports

    assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

// File: src/fwd_hazard.sv
/* Operand forwarding and hazard detection
   Picks the newest rs1/rs2 value and flags hazards needing a bubble */

`timescale 1ns/1ps
`include "disp_cfg.svh"

module fwd_hazard import disp_pkg::*; (
    input  logic [4:0]            rs1,          // Source register 1
    input  logic [4:0]            rs2,          // Source register 2
    input  logic [`DISP_XLEN-1:0] rs1_file,     // Register file value rs1
    input  logic [`DISP_XLEN-1:0] rs2_file,     // Register file value rs2
    input  fwd_t                  fwd_s3,       // Execute stage result
    input  fwd_t                  fwd_s4,       // Writeback stage result
    output logic [`DISP_XLEN-1:0] rs1_val,      // Forwarded rs1
    output logic [`DISP_XLEN-1:0] rs2_val,      // Forwarded rs2
    output logic                  bubble        // Stall dispatch
);

    logic s3_late;                              // s3 data not ready yet
    logic s3_hit;
    logic s4_hit;

    // Newest value wins, x0 never forwarded
    function automatic logic [`DISP_XLEN-1:0] pick(
        input logic [4:0]            src,
        input logic [`DISP_XLEN-1:0] file_val,
        input fwd_t                  s3,
        input fwd_t                  s4
    );
        logic [`DISP_XLEN-1:0] val;
        val = file_val;
        if (src != 5'd0) begin
            if (src == s3.rd) begin
                val = s3.wdata;                 // Stage 3 is newer
            end else if (src == s4.rd) begin
                val = s4.wdata;
            end
        end
        return val;
    endfunction

    assign rs1_val = pick(rs1, rs1_file, fwd_s3, fwd_s4);
    assign rs2_val = pick(rs2, rs2_file, fwd_s3, fwd_s4);

    // ----------------------------------------
    // Hazards

    // Loads in s4 have their data, only s3 loads stall
    assign s3_late = fwd_s3.load || fwd_s3.csr;
    assign s3_hit  = (rs1 == fwd_s3.rd) || (rs2 == fwd_s3.rd);  // Address compare only
    assign s4_hit  = (rs1 == fwd_s4.rd) || (rs2 == fwd_s4.rd);

    assign bubble  = (s3_late && s3_hit) || (fwd_s4.csr && s4_hit);

endmodule

// File: src/pipe_reg.sv
/* Single-entry valid/busy pipeline register
   Carries the dispatched bundle into stage 3, cleared by flush */

`timescale 1ns/1ps

module pipe_reg import disp_pkg::*; (
    input  logic       g_clk,                   // Core clock
    input  logic       g_resetn,                // Sync reset, active low
    input  s3_bundle_t in_data,                 // From dispatch
    input  logic       in_valid,
    output logic       in_busy,                 // Cannot take new item
    input  logic       flush,                   // Drop held item
    output s3_bundle_t out_data,                // To stage 3
    output logic       out_valid,
    input  logic       out_busy                 // Stage 3 stalled
);

    logic load;

    // Stalls only while holding an item that stage 3 refuses
    assign in_busy = out_valid && out_busy;
    assign load    = !in_busy;                  // Empty or item leaving

    // ----------------------------------------
    // Control

    always_ff @(posedge g_clk) begin
        if (!g_resetn || flush) begin
            out_valid <= 1'b0;
        end else if (load) begin
            out_valid <= in_valid;              // Low on a bubble
        end
    end

    // ----------------------------------------
    // Payload

    always_ff @(posedge g_clk) begin
        if (load && in_valid) begin
            out_data <= in_data;
        end
    end

endmodule

// File: src/dispatch_stage.sv
/* Dispatch stage of the core backend
   Tracks the decode PC, gathers forwarded operands and stalls on hazards */

`timescale 1ns/1ps
`include "disp_cfg.svh"

module dispatch_stage import disp_pkg::*; (
    input  logic                  g_clk,        // Core clock
    input  logic                  g_resetn,     // Sync reset, active low
    input  s2_bundle_t            s2,           // Decoded instruction
    input  logic                  s2_valid,
    output logic                  s2_busy,      // Hold s2
    input  logic                  flush,        // Empty the stage
    input  logic                  cf_req,       // Control flow change
    input  logic                  cf_ack,
    input  logic [`DISP_XLEN-1:0] cf_target,    // New PC
    input  fwd_t                  fwd_s3,       // Execute stage result
    input  fwd_t                  fwd_s4,       // Writeback stage result
    input  logic [`DISP_XLEN-1:0] rs1_data,     // Register file read 1
    input  logic [`DISP_XLEN-1:0] rs2_data,     // Register file read 2
    output s3_bundle_t            s3,           // Dispatched instruction
    output logic                  s3_valid,
    input  logic                  s3_busy
);

    logic [`DISP_XLEN-1:0] pc;                  // Decode aligned PC
    logic [`DISP_XLEN-1:0] pc_step;
    logic [`DISP_XLEN-1:0] pc_plus_imm;
    logic [`DISP_XLEN-1:0] rs1_val;
    logic [`DISP_XLEN-1:0] rs2_val;
    logic [`DISP_XLEN-1:0] csr_imm;
    logic [`DISP_XLEN-1:0] csr_addr;
    logic                  bubble;
    logic                  pipe_busy;
    logic                  accept;
    logic                  cfu_cond;
    logic                  no_rd;
    s3_bundle_t            n_s3;

    // ----------------------------------------
    // Handshake

    assign s2_busy = bubble || pipe_busy;       // Hazard or back-pressure
    assign accept  = s2_valid && !s2_busy;

    // ----------------------------------------
    // Program counter

    assign pc_step = {{(`DISP_XLEN-3){1'b0}}, s2.size[1],      // +4 for 32-bit
                      s2.size[0] & ~s2.size[1], 1'b0};          // Else +2 for 16-bit

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            pc <= `DISP_PC_RESET;
        end else if (cf_req && cf_ack) begin
            pc <= cf_target;                    // Redirect beats advance
        end else if (accept) begin
            pc <= pc + pc_step;
        end
    end

    assign pc_plus_imm = pc + s2.imm;           // Branch and AUIPC targets

    // ----------------------------------------
    // Operand gathering

    fwd_hazard fwd_hazard_i (
        .rs1      (s2.rs1),
        .rs2      (s2.rs2),
        .rs1_file (rs1_data),
        .rs2_file (rs2_data),
        .fwd_s3   (fwd_s3),
        .fwd_s4   (fwd_s4),
        .rs1_val  (rs1_val),
        .rs2_val  (rs2_val),
        .bubble   (bubble)
    );

    assign csr_imm  = {{(`DISP_XLEN-5){1'b0}}, s2.rs1};         // rs1 field as uimm
    assign csr_addr = {{(`DISP_XLEN-12){1'b0}}, s2.imm[31:20]};

    // Branches and stores write nothing, a trap keeps rd for the cause
    assign cfu_cond = (s2.fu == FU_CFU) && ((s2.uop == CFU_BEQ) || (s2.uop == CFU_BNE));
    assign no_rd    = (((s2.fu == FU_LSU) && (s2.uop == LSU_STORE)) || cfu_cond) && !s2.trap;

    always_comb begin
        n_s3.rd    = no_rd ? 5'd0 : s2.rd;
        n_s3.pc    = pc;
        n_s3.uop   = s2.uop;
        n_s3.fu    = s2.fu;
        n_s3.size  = s2.size;
        n_s3.instr = s2.instr;
        n_s3.trap  = s2.trap;

        case (s2.opr_src.a)
            OPRA_RS1:  n_s3.opr_a = rs1_val;
            OPRA_PCIM: n_s3.opr_a = pc_plus_imm;
            OPRA_CSRI: n_s3.opr_a = csr_imm;
            default:   n_s3.opr_a = '0;         // NONE
        endcase

        case (s2.opr_src.b)
            OPRB_RS2: n_s3.opr_b = rs2_val;
            OPRB_IMM: n_s3.opr_b = s2.imm;
            default:  n_s3.opr_b = '0;
        endcase

        case (s2.opr_src.c)
            OPRC_RS2:  n_s3.opr_c = rs2_val;    // Store data
            OPRC_CSRA: n_s3.opr_c = csr_addr;
            OPRC_PCIM: n_s3.opr_c = pc_plus_imm;
            default:   n_s3.opr_c = '0;
        endcase
    end

    // ----------------------------------------
    // Stage 3 register

    pipe_reg pipe_reg_i (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .in_data   (n_s3),
        .in_valid  (s2_valid && !bubble),       // Bubble loads an empty slot
        .in_busy   (pipe_busy),
        .flush     (flush),
        .out_data  (s3),
        .out_valid (s3_valid),
        .out_busy  (s3_busy)
    );

endmodule

// File: src/dispatch_top.sv
/* Dispatch top level
   Dispatch stage with its register file */

`timescale 1ns/1ps
`include "disp_cfg.svh"

module dispatch_top import disp_pkg::*; (
    input  logic                  g_clk,        // Core clock
    input  logic                  g_resetn,     // Sync reset, active low
    input  s2_bundle_t            s2,           // From decode
    input  logic                  s2_valid,
    output logic                  s2_busy,
    input  logic                  flush,
    input  logic                  cf_req,
    input  logic                  cf_ack,
    input  logic [`DISP_XLEN-1:0] cf_target,
    input  fwd_t                  fwd_s3,
    input  fwd_t                  fwd_s4,
    input  gpr_wr_t               gpr_wr,       // From writeback
    output s3_bundle_t            s3,           // To execute
    output logic                  s3_valid,
    input  logic                  s3_busy
);

    logic [`DISP_XLEN-1:0] rs1_data;
    logic [`DISP_XLEN-1:0] rs2_data;

    gpr_file gpr_file_i (
        .g_clk    (g_clk),
        .g_resetn (g_resetn),
        .rs1_addr (s2.rs1),                     // Read straight from decode
        .rs1_data (rs1_data),
        .rs2_addr (s2.rs2),
        .rs2_data (rs2_data),
        .wr       (gpr_wr)
    );

    dispatch_stage dispatch_stage_i (
        .g_clk     (g_clk),
        .g_resetn  (g_resetn),
        .s2        (s2),
        .s2_valid  (s2_valid),
        .s2_busy   (s2_busy),
        .flush     (flush),
        .cf_req    (cf_req),
        .cf_ack    (cf_ack),
        .cf_target (cf_target),
        .fwd_s3    (fwd_s3),
        .fwd_s4    (fwd_s4),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .s3        (s3),
        .s3_valid  (s3_valid),
        .s3_busy   (s3_busy)
    );

endmodule

// File: tests/dispatch_props.sv
/* Dispatch stage assertions
   Reset, hold and stall rules bound into the dispatch stage */

`timescale 1ns/1ps

module dispatch_props import disp_pkg::*; (
    input logic       g_clk,
    input logic       g_resetn,
    input logic       flush,
    input logic       bubble,       // Hazard from forwarding block
    input s3_bundle_t s3,
    input logic       s3_valid,
    input logic       s3_busy
);

    // Stage 3 register empty out of reset
    reset_empty: assert property (@(posedge g_clk) !g_resetn |=> !s3_valid)
        else $error("s3_valid high after reset");

    // Held item frozen while stage 3 stalls
    hold_stable: assert property (@(posedge g_clk) disable iff (!g_resetn)
        (s3_valid && s3_busy && !flush) |=> (s3_valid && $stable(s3)))
        else $error("s3 changed while s3_busy held it");

    // Hazard leaves an empty slot in stage 3
    stall_on_bubble: assert property (@(posedge g_clk) disable iff (!g_resetn)
        (bubble && !s3_busy) |=> !s3_valid)
        else $error("bubble did not leave stage 3 empty");

endmodule

bind dispatch_stage dispatch_props dispatch_props_i (
    .g_clk    (g_clk),
    .g_resetn (g_resetn),
    .flush    (flush),
    .bubble   (bubble),
    .s3       (s3),
    .s3_valid (s3_valid),
    .s3_busy  (s3_busy)
);

// File: tests/dispatch_tb.sv
/* Dispatch stage testbench
   Table-driven rows against a register and PC model of the stage */

`timescale 1ns/1ps
`include "disp_cfg.svh"

module dispatch_tb import disp_pkg::*; ();

    localparam int          NROWS        = 13;
    localparam int          RESET_CYCLES = 10;
    localparam logic [31:0] CF_TARGET    = 32'h8000_1000;  // Redirect destination
    localparam fwd_t        IDLE         = '0;             // No result in flight

    typedef struct packed {
        logic       wr_en;          // Register write before the item
        logic [4:0] wr_rd;
        fwd_t       f3;
        fwd_t       f4;
        s2_bundle_t s2;
        logic       cf;             // Redirect before the item
        logic [1:0] hold;           // s3_busy cycles after dispatch
        logic       flush;          // Drop the item while held
        logic       bubble;         // Expect a hazard stall first
    } row_t;

    logic        g_clk;
    logic        g_resetn;
    s2_bundle_t  s2;
    logic        s2_valid;
    logic        s2_busy;
    logic        flush;
    logic        cf_req;
    logic        cf_ack;
    logic [31:0] cf_target;
    fwd_t        fwd_s3;
    fwd_t        fwd_s4;
    gpr_wr_t     gpr_wr;
    s3_bundle_t  s3;
    logic        s3_valid;
    logic        s3_busy;

    row_t        rows [NROWS];
    string       row_name [NROWS];
    int          nrows;
    int          errors;
    int          failed_rows;
    logic [31:0] lfsr;
    logic [31:0] ref_regs [32];     // Register file model
    logic [31:0] pc_model;
    fwd_t        cur_f3;            // Forwarding inputs as driven
    fwd_t        cur_f4;

    dispatch_top dispatch_top_i (.*);

    always #50 g_clk = ~g_clk;

    // ----------------------------------------
    // Helpers

    // 32-bit Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_word();
        logic [31:0] word;
        logic        fb;
        word = '0;
        for (int i = 0; i < 32; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            word = {word[30:0], fb};                // One step per bit
        end
        return word;
    endfunction

    // Newest value of a source register
    function automatic logic [31:0] src_value(input logic [4:0] r);
        if (r == 5'd0) return '0;
        if (cur_f3.rd == r) return cur_f3.wdata;
        if (cur_f4.rd == r) return cur_f4.wdata;
        return ref_regs[r];
    endfunction

    function automatic fwd_t mk_fwd(input logic [4:0] rd, input logic [31:0] wdata,
                                    input logic load, input logic csr);
        return '{rd, wdata, load, csr};
    endfunction

    function automatic s2_bundle_t mk_s2(input uop_e uop, input fu_e fu, input logic [4:0] rd,
                                         input logic [4:0] rs1, input logic [4:0] rs2,
                                         input logic [31:0] imm, input logic [1:0] size,
                                         input logic trap);
        s2_bundle_t s;
        s       = '0;
        s.rd    = rd;
        s.rs1   = rs1;
        s.rs2   = rs2;
        s.imm   = imm;
        s.uop   = uop;
        s.fu    = fu;
        s.trap  = trap;
        s.size  = size;
        s.instr = {imm[11:0], rs1, 3'b000, rd, 7'h13};   // I-type shaped word
        return s;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic add_row(input string name, input logic wr_en, input logic [4:0] wr_rd,
                           input fwd_t f3, input fwd_t f4, input s2_bundle_t s,
                           input logic cf, input logic [1:0] hold, input logic flush_it,
                           input logic bubble);
        rows[nrows]     = '{wr_en, wr_rd, f3, f4, s, cf, hold, flush_it, bubble};
        row_name[nrows] = name;
        nrows++;
    endtask

    // ----------------------------------------
    // Stimulus table

    task automatic build_table();
        s2_bundle_t s;
        s = mk_s2(ALU_ADD, FU_ALU, 5'd3, 5'd1, 5'd0, 32'h10, 2'b10, 1'b0);
        s.opr_src = '{OPRA_RS1, OPRB_IMM, OPRC_NONE};
        add_row("reset pc", 1'b1, 5'd1, IDLE, IDLE, s, 1'b0, 2'd0, 1'b0, 1'b0);
        s = mk_s2(ALU_ADD, FU_ALU, 5'd4, 5'd1, 5'd2, 32'h0, 2'b01, 1'b0);    // 16-bit
        s.opr_src = '{OPRA_RS1, OPRB_RS2, OPRC_NONE};
        add_row("rs2 read, pc +4", 1'b1, 5'd2, IDLE, IDLE, s, 1'b0, 2'd0, 1'b0, 1'b0);
        s = mk_s2(ALU_ADD, FU_ALU, 5'd4, 5'd0, 5'd1, 32'h4, 2'b10, 1'b0);
        s.opr_src = '{OPRA_RS1, OPRB_RS2, OPRC_NONE};
        add_row("x0 write, pc +2", 1'b1, 5'd0, IDLE, IDLE, s, 1'b0, 2'd0, 1'b0, 1'b0);
        s = mk_s2(ALU_ADD, FU_ALU, 5'd4, 5'd1, 5'd2, 32'h0, 2'b10, 1'b0);
        s.opr_src = '{OPRA_RS1, OPRB_RS2, OPRC_NONE};
        add_row("fwd s3 over s4", 1'b0, 5'd0, mk_fwd(5'd1, 32'hA5A5_0001, 1'b0, 1'b0),
                mk_fwd(5'd1, 32'h5A5A_0002, 1'b0, 1'b0), s, 1'b0, 2'd0, 1'b0, 1'b0);
        add_row("fwd s4 over file", 1'b0, 5'd0, IDLE,
                mk_fwd(5'd2, 32'h0000_BEEF, 1'b0, 1'b0), s, 1'b0, 2'd0, 1'b0, 1'b0);
        s.opr_src = '{OPRA_RS1, OPRB_IMM, OPRC_NONE};
        add_row("s3 load hazard", 1'b1, 5'd1, mk_fwd(5'd1, 32'hDEAD_0001, 1'b1, 1'b0),
                IDLE, s, 1'b0, 2'd0, 1'b0, 1'b1);
        add_row("s4 csr hazard", 1'b0, 5'd0, IDLE,
                mk_fwd(5'd1, 32'hDEAD_0003, 1'b0, 1'b1), s, 1'b0, 2'd0, 1'b0, 1'b1);
        s = mk_s2(ALU_ADD, FU_ALU, 5'd4, 5'd0, 5'd2, 32'h0, 2'b10, 1'b0);
        s.opr_src = '{OPRA_NONE, OPRB_RS2, OPRC_NONE};
        add_row("s3 csr hazard", 1'b0, 5'd0, mk_fwd(5'd2, 32'hDEAD_0002, 1'b0, 1'b1),
                IDLE, s, 1'b0, 2'd0, 1'b0, 1'b1);
        s = mk_s2(CSR_RW, FU_CSR, 5'd8, 5'd7, 5'd0, 32'h3400_0000, 2'b10, 1'b0);
        s.opr_src = '{OPRA_CSRI, OPRB_NONE, OPRC_CSRA};
        add_row("csr operands", 1'b0, 5'd0, IDLE, IDLE, s, 1'b0, 2'd0, 1'b0, 1'b0);
        s = mk_s2(CFU_JAL, FU_CFU, 5'd1, 5'd0, 5'd0, 32'h100, 2'b10, 1'b0);
        s.opr_src = '{OPRA_PCIM, OPRB_IMM, OPRC_PCIM};
        add_row("redirect jal", 1'b0, 5'd0, IDLE, IDLE, s, 1'b1, 2'd0, 1'b0, 1'b0);
        s = mk_s2(LSU_STORE, FU_LSU, 5'd9, 5'd1, 5'd2, 32'h8, 2'b10, 1'b0);
        s.opr_src = '{OPRA_RS1, OPRB_IMM, OPRC_RS2};
        add_row("store, back-pressure", 1'b0, 5'd0, IDLE, IDLE, s, 1'b0, 2'd3, 1'b0, 1'b0);
        s = mk_s2(CFU_BEQ, FU_CFU, 5'd6, 5'd1, 5'd2, 32'hFFFF_FFF0, 2'b10, 1'b0);
        s.opr_src = '{OPRA_RS1, OPRB_RS2, OPRC_PCIM};
        add_row("beq rd zero", 1'b0, 5'd0, IDLE, IDLE, s, 1'b0, 2'd0, 1'b0, 1'b0);
        s.trap = 1'b1;                                  // Trap keeps rd
        add_row("beq trap, flush", 1'b0, 5'd0, IDLE, IDLE, s, 1'b0, 2'd1, 1'b1, 1'b0);
    endtask

    // ----------------------------------------
    // Row sequence

    task automatic run_row(input int idx);
        row_t        r;
        s2_bundle_t  s;
        s3_bundle_t  held;
        logic [31:0] wdata;
        logic [31:0] pcim;
        logic [31:0] exp_a;
        logic [31:0] exp_b;
        logic [31:0] exp_c;
        logic [31:0] cur_pc;
        logic [4:0]  exp_rd;
        int          tries;
        r     = rows[idx];
        s     = r.s2;
        wdata = '0;
        if (r.wr_en) begin
            wdata = lfsr_word();
            if (r.wr_rd != 5'd0) ref_regs[r.wr_rd] = wdata;    // x0 stays zero
        end
        @(posedge g_clk);
        gpr_wr <= '{r.wr_en, r.wr_rd, wdata};
        @(posedge g_clk);                               // Write lands here
        gpr_wr <= '0;
        if (r.cf) begin
            cf_req    <= 1'b1;
            cf_ack    <= 1'b1;
            cf_target <= CF_TARGET;
            @(posedge g_clk);
            cf_req   <= 1'b0;
            cf_ack   <= 1'b0;
            pc_model = CF_TARGET;
        end
        s2       <= s;
        s2_valid <= 1'b1;
        fwd_s3   <= r.f3;
        fwd_s4   <= r.f4;
        cur_f3   = r.f3;
        cur_f4   = r.f4;
        @(negedge g_clk);
        if (r.bubble) begin
            check("s2_busy", 32'(s2_busy), 32'd1);
            @(negedge g_clk);                           // Bubble entered stage 3
            check("s3_valid", 32'(s3_valid), 32'd0);
            @(posedge g_clk);
            fwd_s3 <= IDLE;                             // Hazard clears
            fwd_s4 <= IDLE;
            cur_f3 = IDLE;
            cur_f4 = IDLE;
            @(negedge g_clk);
        end
        tries = 0;
        while (s2_busy && tries < 10) begin
            @(negedge g_clk);
            tries++;
        end
        if (s2_busy) begin
            $display("Row %0d: s2_busy stayed high, the item was never accepted", idx);
            errors++;
        end
        // Expected operands from the select rules
        pcim = pc_model + s.imm;
        case (s.opr_src.a)
            OPRA_RS1:  exp_a = src_value(s.rs1);
            OPRA_PCIM: exp_a = pcim;
            OPRA_CSRI: exp_a = {27'd0, s.rs1};
            default:   exp_a = '0;
        endcase
        case (s.opr_src.b)
            OPRB_RS2: exp_b = src_value(s.rs2);
            OPRB_IMM: exp_b = s.imm;
            default:  exp_b = '0;
        endcase
        case (s.opr_src.c)
            OPRC_RS2:  exp_c = src_value(s.rs2);
            OPRC_CSRA: exp_c = {20'd0, s.imm[31:20]};
            OPRC_PCIM: exp_c = pcim;
            default:   exp_c = '0;
        endcase
        exp_rd = s.rd;
        if (!s.trap && (s.uop == LSU_STORE || s.uop == CFU_BEQ || s.uop == CFU_BNE)) begin
            exp_rd = 5'd0;                              // Writes no register
        end
        @(posedge g_clk);                               // Accept edge
        s2_valid <= 1'b0;
        fwd_s3   <= IDLE;
        fwd_s4   <= IDLE;
        s3_busy  <= (r.hold != 2'd0);
        cur_pc   = pc_model;
        pc_model = pc_model + (s.size[1] ? 32'd4 : (s.size[0] ? 32'd2 : 32'd0));
        @(negedge g_clk);
        check("s3_valid", 32'(s3_valid), 32'd1);
        check("s3.pc", s3.pc, cur_pc);
        check("s3.rd", 32'(s3.rd), 32'(exp_rd));
        check("s3.uop", 32'(s3.uop), 32'(s.uop));
        check("s3.fu", 32'(s3.fu), 32'(s.fu));
        check("s3.size", 32'(s3.size), 32'(s.size));
        check("s3.trap", 32'(s3.trap), 32'(s.trap));
        check("s3.instr", s3.instr, s.instr);
        check("s3.opr_a", s3.opr_a, exp_a);
        check("s3.opr_b", s3.opr_b, exp_b);
        check("s3.opr_c", s3.opr_c, exp_c);
        held = s3;
        repeat (r.hold) begin
            @(negedge g_clk);
            check("s3_valid", 32'(s3_valid), 32'd1);   // Item still offered
            check("s3_held", 32'(s3 == held), 32'd1);
            check("s2_busy", 32'(s2_busy), 32'd1);
        end
        if (r.flush) begin
            @(posedge g_clk);
            flush <= 1'b1;
            @(posedge g_clk);
            flush   <= 1'b0;
            s3_busy <= 1'b0;
            @(negedge g_clk);
            check("s3_valid", 32'(s3_valid), 32'd0);   // Item dropped
        end else begin
            @(posedge g_clk);
            s3_busy <= 1'b0;
        end
    endtask

    // ----------------------------------------
    // Main sequence and watchdog

    initial begin
        int errs_before;
        g_clk     = 1'b0;
        g_resetn  = 1'b0;
        s2        = '0;
        s2_valid  = 1'b0;
        flush     = 1'b0;
        cf_req    = 1'b0;
        cf_ack    = 1'b0;
        cf_target = '0;
        fwd_s3    = IDLE;
        fwd_s4    = IDLE;
        gpr_wr    = '0;
        s3_busy   = 1'b0;
        cur_f3    = IDLE;
        cur_f4    = IDLE;
        lfsr      = 32'd11;                             // Seed
        pc_model  = `DISP_PC_RESET;
        errors    = 0;
        failed_rows = 0;
        nrows     = 0;
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        build_table();
        repeat (RESET_CYCLES) @(posedge g_clk);
        g_resetn <= 1'b1;
        @(negedge g_clk);
        check("s3_valid", 32'(s3_valid), 32'd0);
        check("s2_busy", 32'(s2_busy), 32'd0);
        for (int i = 0; i < NROWS; i++) begin
            errs_before = errors;
            run_row(i);
            if (errors == errs_before) begin
                $display("Row %0d %s: ok", i, row_name[i]);
            end else begin
                $display("Row %0d %s: failed with %0d errors", i, row_name[i],
                         errors - errs_before);
                failed_rows++;
            end
        end
        $display("Rows run %0d, rows failed %0d, check errors %0d", NROWS, failed_rows, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (RESET_CYCLES + NROWS * 20) @(posedge g_clk);     // 20 cycles per row
        $display("Watchdog expired, the rows did not finish in time");
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// File: tb.f
+incdir+src
src/disp_pkg.sv
src/gpr_file.sv
src/fwd_hazard.sv
src/pipe_reg.sv
src/dispatch_stage.sv
src/dispatch_top.sv
tests/dispatch_props.sv
tests/dispatch_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the dispatch testbench with Verilator and run it
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f --top-module dispatch_tb
./obj_dir/Vdispatch_tb | tee sim.log

if grep -q "STATUS: FAIL" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
echo "Simulation finished without failure"
